// File: hw/saturnBusPkg.sv
package saturnBusPkg;

	localparam int ADDR_W = 25;
	localparam int DATA_W = 32;
	localparam int SEL_W  = 4;

	// Region field of the address, bits 24..21
	typedef enum logic [3:0] {
		RGN_ROM  = 4'h0,
		RGN_RAML = 4'h1,
		RGN_SRAM = 4'h2,
		RGN_REGS = 4'h3,
		RGN_RAMH = 4'h8
	} region_e;

	typedef struct packed {
		region_e     region;
		logic [20:0] offset;
	} memView_t;

	typedef struct packed {
		region_e     region;
		logic [14:0] spare;
		logic [3:0]  index;
		logic [1:0]  byteSel;
	} regView_t;

	// One address word, seen as memory address or register index
	typedef union packed {
		memView_t memView;
		regView_t regView;
	} busAddr_t;

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [SEL_W-1:0]  sel;
		busAddr_t          adr;
		logic [DATA_W-1:0] dat;
	} wbReq_t;

	typedef struct packed {
		logic [DATA_W-1:0] dat;
		logic              ack;
	} wbRsp_t;

	typedef struct packed {
		logic romCsN;
		logic sramCsN;
		logic ramlCsN;
		logic ramhCsN;
	} chipSel_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [SEL_W-1:0]  dqmN;
		logic              rdN;
		chipSel_t          cs;
	} memReq_t;

	// Debug register window
	localparam logic [3:0] REG_CTRL   = 4'd0;
	localparam logic [3:0] REG_HOOK   = 4'd1;
	localparam logic [3:0] REG_STATUS = 4'd2;

endpackage

// File: hw/busRouter.sv
`timescale 1ns/1ps

module busRouter (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  saturnBusPkg::wbReq_t   wbReq,
	output logic                   memStart,
	output saturnBusPkg::chipSel_t memCs,
	output logic                   regStart,
	input  saturnBusPkg::wbRsp_t   memRsp,
	input  saturnBusPkg::wbRsp_t   regRsp,
	output saturnBusPkg::wbRsp_t   wbRsp
);
	import saturnBusPkg::*;

	logic     accOpen;
	logic     start;
	logic     isMem;
	logic     isReg;
	logic     nullAck;
	chipSel_t cs;

	// New access only when nothing is in flight
	assign start = wbReq.cyc && wbReq.stb && !accOpen;

	always_comb begin
		cs = '1;
		isReg = 1'b0;
		case (wbReq.adr.memView.region)
			RGN_ROM: begin
				// ROM writes fall through to the null target
				cs.romCsN = wbReq.we;
			end
			RGN_RAML: begin
				cs.ramlCsN = 1'b0;
			end
			RGN_SRAM: begin
				cs.sramCsN = 1'b0;
			end
			RGN_REGS: begin
				isReg = 1'b1;
			end
			default: begin
				cs.ramhCsN = (wbReq.adr.memView.region < RGN_RAMH);
			end
		endcase
	end

	assign isMem    = !(&cs);
	assign memCs    = cs;
	assign memStart = start && isMem;
	assign regStart = start && isReg;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			accOpen <= 1'b0;
			nullAck <= 1'b0;
		end else begin
			nullAck <= start && !isMem && !isReg;
			if (wbRsp.ack) begin
				accOpen <= 1'b0;
			end else if (start) begin
				accOpen <= 1'b1;
			end
		end
	end

	// Targets drive zero data unless acking
	always_comb begin
		wbRsp.ack = memRsp.ack | regRsp.ack | nullAck;
		wbRsp.dat = memRsp.dat | regRsp.dat | {DATA_W{nullAck}};
	end

endmodule

// File: hw/memSequencer.sv
`timescale 1ns/1ps

module memSequencer (
	input  logic                            CLK,
	input  logic                            RST_N,
	input  saturnBusPkg::wbReq_t            wbReq,
	input  logic                            memStart,
	input  saturnBusPkg::chipSel_t          memCs,
	input  logic                            pause,
	output saturnBusPkg::memReq_t           memReq,
	input  logic [saturnBusPkg::DATA_W-1:0] memDi,
	input  logic                            memWaitN,
	output saturnBusPkg::wbRsp_t            memRsp
);
	import saturnBusPkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HELD,
		ST_ACTIVE,
		ST_DONE
	} seqState_e;

	seqState_e         state;
	logic [ADDR_W-1:0] addrQ;
	logic [DATA_W-1:0] dataQ;
	logic [SEL_W-1:0]  dqmNQ;
	logic              rdNQ;
	chipSel_t          csQ;
	logic [DATA_W-1:0] rdData;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (memStart) begin
						state <= pause ? ST_HELD : ST_ACTIVE;
					end
				end
				ST_HELD: begin
					if (!pause) begin
						state <= ST_ACTIVE;
					end
				end
				ST_ACTIVE: begin
					// Wait states stretch this phase
					if (memWaitN) begin
						state <= ST_DONE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (memStart) begin
			addrQ <= wbReq.adr;
			dataQ <= wbReq.dat;
			dqmNQ <= wbReq.we ? ~wbReq.sel : '1;
			rdNQ  <= wbReq.we;
			csQ   <= memCs;
		end
		if (state == ST_ACTIVE && memWaitN) begin
			rdData <= memDi;
		end
	end

	// Bus is quiet outside the active phase
	always_comb begin
		memReq = '{addr: '0, data: '0, dqmN: '1, rdN: 1'b1, cs: '1};
		if (state == ST_ACTIVE) begin
			memReq = '{addr: addrQ, data: dataQ, dqmN: dqmNQ, rdN: rdNQ, cs: csQ};
		end
	end

	assign memRsp.ack = (state == ST_DONE);
	assign memRsp.dat = memRsp.ack ? rdData : '0;

endmodule

// File: hw/debugRegs.sv
`timescale 1ns/1ps

module debugRegs #(
	parameter logic [saturnBusPkg::ADDR_W-1:0] HOOK_ADDR_INIT = '0
) (
	input  logic                            CLK,
	input  logic                            RST_N,
	input  saturnBusPkg::wbReq_t            wbReq,
	input  logic                            regStart,
	output saturnBusPkg::wbRsp_t            regRsp,
	input  logic                            dbgPause,
	input  logic                            dbgRun,
	input  logic                            hookHit,
	input  logic [7:0]                      waitCnt,
	output logic                            pause,
	output logic [saturnBusPkg::ADDR_W-1:0] hookAddr,
	output logic                            dbgHook
);
	import saturnBusPkg::*;

	logic              breakFlag;
	logic              brkOnHook;
	logic              hookFlag;
	logic              ackQ;
	logic [3:0]        index;
	logic              wrCtrl;
	logic              wrHook;
	logic [DATA_W-1:0] rdMux;
	logic [DATA_W-1:0] rdData;

	assign index  = wbReq.adr.regView.index;
	assign wrCtrl = regStart && wbReq.we && (index == REG_CTRL);
	assign wrHook = regStart && wbReq.we && (index == REG_HOOK);

	assign pause   = dbgPause | breakFlag;
	assign dbgHook = hookFlag;

	always_comb begin
		rdMux = '0;
		case (index)
			REG_CTRL:   rdMux[1:0] = {brkOnHook, breakFlag};
			REG_HOOK:   rdMux[ADDR_W-1:0] = hookAddr;
			REG_STATUS: rdMux[9:0] = {pause, hookFlag, waitCnt};
			default:    rdMux = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			breakFlag <= 1'b0;
			brkOnHook <= 1'b0;
			hookFlag  <= 1'b0;
			hookAddr  <= HOOK_ADDR_INIT;
			ackQ      <= 1'b0;
		end else begin
			ackQ <= regStart;
			if (dbgRun) begin
				breakFlag <= 1'b0;
			end
			if (wrCtrl) begin
				brkOnHook <= wbReq.dat[1];
				// Writing 0 leaves break alone
				if (wbReq.dat[0]) begin
					breakFlag <= 1'b1;
				end
			end
			if (wrHook) begin
				hookAddr <= wbReq.dat[ADDR_W-1:0];
				hookFlag <= 1'b0;
			end
			if (hookHit) begin
				hookFlag <= 1'b1;
				if (brkOnHook) begin
					breakFlag <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (regStart) begin
			rdData <= rdMux;
		end
	end

	assign regRsp.ack = ackQ;
	assign regRsp.dat = ackQ ? rdData : '0;

endmodule

// File: hw/debugMonitor.sv
`timescale 1ns/1ps

module debugMonitor (
	input  logic                            CLK,
	input  logic                            RST_N,
	input  saturnBusPkg::wbReq_t            wbReq,
	input  saturnBusPkg::wbRsp_t            wbRsp,
	input  logic [saturnBusPkg::ADDR_W-1:0] hookAddr,
	output logic                            hookHit,
	output logic [7:0]                      waitCnt
);
	logic ackedRead;
	logic addrMatch;

	assign ackedRead = wbRsp.ack && wbReq.cyc && wbReq.stb && !wbReq.we;
	assign addrMatch = (wbReq.adr == hookAddr);

	// Idle cycles since the last completed access, wraps at 256
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			waitCnt <= 8'd0;
		end else if (wbRsp.ack) begin
			waitCnt <= 8'd0;
		end else begin
			waitCnt <= waitCnt + 8'd1;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			hookHit <= 1'b0;
		end else begin
			hookHit <= ackedRead && addrMatch;
		end
	end

endmodule

// File: hw/saturnBus.sv
`timescale 1ns/1ps

module saturnBus #(
	parameter logic [saturnBusPkg::ADDR_W-1:0] HOOK_ADDR_INIT = 25'h00012B0
) (
	input  logic                            CLK,
	input  logic                            RST_N,
	input  saturnBusPkg::wbReq_t            wbReq,
	output saturnBusPkg::wbRsp_t            wbRsp,
	output saturnBusPkg::memReq_t           memReq,
	input  logic [saturnBusPkg::DATA_W-1:0] memDi,
	input  logic                            memWaitN,
	input  logic                            dbgPause,
	input  logic                            dbgRun,
	output logic                            dbgHook,
	output logic [7:0]                      dbgWaitCnt
);
	import saturnBusPkg::*;

	logic              memStart;
	logic              regStart;
	chipSel_t          memCs;
	wbRsp_t            memRsp;
	wbRsp_t            regRsp;
	logic              pause;
	logic [ADDR_W-1:0] hookAddr;
	logic              hookHit;

	busRouter busRouter_inst (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.wbReq    (wbReq),
		.memStart (memStart),
		.memCs    (memCs),
		.regStart (regStart),
		.memRsp   (memRsp),
		.regRsp   (regRsp),
		.wbRsp    (wbRsp)
	);

	memSequencer memSequencer_inst (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.wbReq    (wbReq),
		.memStart (memStart),
		.memCs    (memCs),
		.pause    (pause),
		.memReq   (memReq),
		.memDi    (memDi),
		.memWaitN (memWaitN),
		.memRsp   (memRsp)
	);

	debugRegs #(
		.HOOK_ADDR_INIT (HOOK_ADDR_INIT)
	) debugRegs_inst (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.wbReq    (wbReq),
		.regStart (regStart),
		.regRsp   (regRsp),
		.dbgPause (dbgPause),
		.dbgRun   (dbgRun),
		.hookHit  (hookHit),
		.waitCnt  (dbgWaitCnt),
		.pause    (pause),
		.hookAddr (hookAddr),
		.dbgHook  (dbgHook)
	);

	// Watches the merged host response
	debugMonitor debugMonitor_inst (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.wbReq    (wbReq),
		.wbRsp    (wbRsp),
		.hookAddr (hookAddr),
		.hookHit  (hookHit),
		.waitCnt  (dbgWaitCnt)
	);

endmodule

// File: sim/saturnBus_chk.sv
`timescale 1ns/1ps

module saturnBus_chk (
	input logic                  CLK,
	input logic                  RST_N,
	input saturnBusPkg::wbReq_t  wbReq,
	input saturnBusPkg::wbRsp_t  wbRsp,
	input saturnBusPkg::memReq_t memReq,
	input logic                  memWaitN
);
	logic [3:0] csLow;

	assign csLow = ~memReq.cs;

	ackNeedsStb: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(wbRsp.ack) |-> (wbReq.cyc && wbReq.stb))
		else $error("ack rose without an active strobe");

	ackOneCycle: assert property (@(posedge CLK) disable iff (!RST_N)
		wbRsp.ack |=> !wbRsp.ack)
		else $error("ack held for more than one cycle");

	oneSelect: assert property (@(posedge CLK) disable iff (!RST_N)
		$onehot0(csLow))
		else $error("more than one chip select low");

	// Wait states freeze the whole memory request
	stableInWait: assert property (@(posedge CLK) disable iff (!RST_N)
		(!memWaitN && csLow != 4'd0) |=> $stable(memReq))
		else $error("memory request changed during a wait state");

endmodule

bind saturnBus saturnBus_chk saturnBus_chk_inst (
	.CLK      (CLK),
	.RST_N    (RST_N),
	.wbReq    (wbReq),
	.wbRsp    (wbRsp),
	.memReq   (memReq),
	.memWaitN (memWaitN)
);

// File: sim/tbSaturnBus.sv
`timescale 1ns/1ps

module tbSaturnBus;
	import saturnBusPkg::*;

	localparam logic [31:0] RD_PATTERN  = 32'h5A3C96E1;
	localparam int          ACK_LIMIT   = 40;
	localparam int          HOLD_CYCLES = 20;
	localparam logic [24:0] HOOK_TARGET = {4'h8, 21'h000040};

	localparam chipSel_t CS_ROM  = '{romCsN: 1'b0, sramCsN: 1'b1, ramlCsN: 1'b1, ramhCsN: 1'b1};
	localparam chipSel_t CS_SRAM = '{romCsN: 1'b1, sramCsN: 1'b0, ramlCsN: 1'b1, ramhCsN: 1'b1};
	localparam chipSel_t CS_RAML = '{romCsN: 1'b1, sramCsN: 1'b1, ramlCsN: 1'b0, ramhCsN: 1'b1};
	localparam chipSel_t CS_RAMH = '{romCsN: 1'b1, sramCsN: 1'b1, ramlCsN: 1'b1, ramhCsN: 1'b0};

	logic              CLK;
	logic              RST_N;
	wbReq_t            wbReq;
	wbRsp_t            wbRsp;
	memReq_t           memReq;
	logic [DATA_W-1:0] memDi;
	logic              memWaitN;
	logic              dbgPause;
	logic              dbgRun;
	logic              dbgHook;
	logic [7:0]        dbgWaitCnt;

	logic [31:0] lcgState;
	logic [31:0] modelRnd;
	int          waitLeft;
	logic        inAccess;
	int          errCount;
	logic        reported;

	saturnBus saturnBus_inst (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.wbReq      (wbReq),
		.wbRsp      (wbRsp),
		.memReq     (memReq),
		.memDi      (memDi),
		.memWaitN   (memWaitN),
		.dbgPause   (dbgPause),
		.dbgRun     (dbgRun),
		.dbgHook    (dbgHook),
		.dbgWaitCnt (dbgWaitCnt)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// External memory, 0 to 3 wait cycles per access
	always @(posedge CLK) begin
		#5;
		if (!(&memReq.cs)) begin
			if (!inAccess) begin
				inAccess = 1'b1;
				modelRnd = nextRandom();
				waitLeft = int'(modelRnd[17:16]);
			end
			memDi = {7'd0, memReq.addr} ^ RD_PATTERN;
			memWaitN = (waitLeft == 0);
			if (waitLeft > 0) begin
				waitLeft--;
			end
		end else begin
			inAccess = 1'b0;
			memWaitN = 1'b1;
		end
	end

	task automatic failStop(input string msg);
		$display("%s", msg);
		errCount++;
		reported = 1'b1;
		$display("Something failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			failStop($sformatf("MISMATCH time=%0t %s got=%08h expected=%08h",
				$time, name, got, exp));
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			failStop($sformatf("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp));
		end
	endtask

	task automatic checkRsp(input string name, input wbRsp_t got, input wbRsp_t exp);
		if (got !== exp) begin
			failStop($sformatf("MISMATCH time=%0t %s got dat=%08h ack=%b expected dat=%08h ack=%b",
				$time, name, got.dat, got.ack, exp.dat, exp.ack));
		end
	endtask

	task automatic checkMemReq(input string name, input memReq_t got, input memReq_t exp);
		if (got !== exp) begin
			failStop($sformatf({"MISMATCH time=%0t %s got addr=%07h data=%08h dqmN=%h rdN=%b cs=%b",
				" expected addr=%07h data=%08h dqmN=%h rdN=%b cs=%b"}, $time, name,
				got.addr, got.data, got.dqmN, got.rdN, got.cs,
				exp.addr, exp.data, exp.dqmN, exp.rdN, exp.cs));
		end
	endtask

	function automatic busAddr_t memAddr(input logic [3:0] rgn, input logic [20:0] off);
		busAddr_t a;
		a.memView.region = region_e'(rgn);
		a.memView.offset = off;
		return a;
	endfunction

	function automatic busAddr_t regAddr(input logic [3:0] idx);
		busAddr_t a;
		a.regView.region  = RGN_REGS;
		a.regView.spare   = '0;
		a.regView.index   = idx;
		a.regView.byteSel = 2'b00;
		return a;
	endfunction

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge CLK);
			#5;
		end
	endtask

	task automatic startAccess(input logic we, input busAddr_t adr, input logic [3:0] sel,
		input logic [31:0] dat);
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we  = we;
		wbReq.sel = sel;
		wbReq.adr = adr;
		wbReq.dat = dat;
	endtask

	task automatic endAccess();
		wbReq.cyc = 1'b0;
		wbReq.stb = 1'b0;
		wbReq.we  = 1'b0;
	endtask

	// Samples at the falling edge, returns just after the next rising edge
	task automatic waitAck(input int limit, output logic acked, output wbRsp_t rsp,
		output logic seenMem, output memReq_t seenReq);
		int cycles;
		acked   = 1'b0;
		seenMem = 1'b0;
		seenReq = '0;
		rsp     = '0;
		cycles  = 0;
		while (!acked && cycles < limit) begin
			@(negedge CLK);
			cycles++;
			if (!(&memReq.cs)) begin
				seenMem = 1'b1;
				seenReq = memReq;
			end
			if (wbRsp.ack) begin
				acked = 1'b1;
				rsp   = wbRsp;
			end
		end
		@(posedge CLK);
		#5;
	endtask

	task automatic memRead(input busAddr_t adr, input chipSel_t cs);
		logic    acked;
		logic    seenMem;
		wbRsp_t  rsp;
		memReq_t seen;
		startAccess(1'b0, adr, 4'hF, '0);
		waitAck(ACK_LIMIT, acked, rsp, seenMem, seen);
		if (!acked) begin
			failStop("memory read got no ack before the timeout");
		end
		checkBit("memory select seen", seenMem, 1'b1);
		checkMemReq("memReq", seen, '{addr: adr, data: '0, dqmN: 4'hF, rdN: 1'b0, cs: cs});
		checkWord("wbRsp.dat", rsp.dat, {7'd0, adr} ^ RD_PATTERN);
		endAccess();
	endtask

	task automatic memWrite(input busAddr_t adr, input chipSel_t cs);
		logic [31:0] r;
		logic [3:0]  sel;
		logic [31:0] dat;
		logic        acked;
		logic        seenMem;
		wbRsp_t      rsp;
		memReq_t     seen;
		r   = nextRandom();
		sel = r[19:16];
		dat = nextRandom();
		startAccess(1'b1, adr, sel, dat);
		waitAck(ACK_LIMIT, acked, rsp, seenMem, seen);
		if (!acked) begin
			failStop("memory write got no ack before the timeout");
		end
		checkBit("memory select seen", seenMem, 1'b1);
		checkMemReq("memReq", seen, '{addr: adr, data: dat, dqmN: ~sel, rdN: 1'b1, cs: cs});
		endAccess();
	endtask

	task automatic regAccess(input logic we, input logic [3:0] idx, input logic [31:0] wdat,
		output logic [31:0] rdat);
		logic    acked;
		logic    seenMem;
		wbRsp_t  rsp;
		memReq_t seen;
		startAccess(we, regAddr(idx), 4'hF, wdat);
		waitAck(ACK_LIMIT, acked, rsp, seenMem, seen);
		if (!acked) begin
			failStop("register access got no ack before the timeout");
		end
		checkBit("memory select during register access", seenMem, 1'b0);
		rdat = rsp.dat;
		endAccess();
	endtask

	task automatic nullAccess(input logic we, input busAddr_t adr);
		logic    acked;
		logic    seenMem;
		wbRsp_t  rsp;
		memReq_t seen;
		startAccess(we, adr, 4'hF, 32'h0BAD0BAD);
		waitAck(ACK_LIMIT, acked, rsp, seenMem, seen);
		if (!acked) begin
			failStop("access to the null target got no ack before the timeout");
		end
		checkBit("memory select during null access", seenMem, 1'b0);
		if (!we) begin
			checkRsp("wbRsp", rsp, '{dat: '1, ack: 1'b1});
		end
		endAccess();
	endtask

	// Read that must stall until break or pause is released
	task automatic heldRead(input busAddr_t adr, input chipSel_t cs, input logic useRun);
		logic    acked;
		logic    seenMem;
		wbRsp_t  rsp;
		memReq_t seen;
		startAccess(1'b0, adr, 4'hF, '0);
		waitAck(HOLD_CYCLES, acked, rsp, seenMem, seen);
		if (acked) begin
			failStop("memory read was acked while the bus was held");
		end
		checkBit("memory select while held", seenMem, 1'b0);
		if (useRun) begin
			dbgRun = 1'b1;
			@(posedge CLK);
			#5;
			dbgRun = 1'b0;
		end else begin
			dbgPause = 1'b0;
		end
		waitAck(ACK_LIMIT, acked, rsp, seenMem, seen);
		if (!acked) begin
			failStop("held memory read got no ack after release");
		end
		checkMemReq("memReq", seen, '{addr: adr, data: '0, dqmN: 4'hF, rdN: 1'b0, cs: cs});
		checkWord("wbRsp.dat", rsp.dat, {7'd0, adr} ^ RD_PATTERN);
		endAccess();
	endtask

	task automatic resetValues();
		checkMemReq("memReq", memReq, '{addr: '0, data: '0, dqmN: 4'hF, rdN: 1'b1, cs: 4'hF});
		checkBit("wbRsp.ack", wbRsp.ack, 1'b0);
		checkBit("dbgHook", dbgHook, 1'b0);
		checkWord("dbgWaitCnt", {24'd0, dbgWaitCnt}, 32'd0);
	endtask

	task automatic memoryAccesses();
		logic [31:0] r;
		for (int i = 0; i < 3; i++) begin
			// Offset bit 20 set keeps clear of both hook addresses
			r = nextRandom();
			memRead(memAddr(4'h0, {1'b1, r[19:2], 2'b00}), CS_ROM);
			r = nextRandom();
			memRead(memAddr(4'h1, {1'b1, r[19:2], 2'b00}), CS_RAML);
			r = nextRandom();
			memRead(memAddr(4'h2, {1'b1, r[19:2], 2'b00}), CS_SRAM);
			r = nextRandom();
			memRead(memAddr({1'b1, r[22:20]}, {1'b1, r[19:2], 2'b00}), CS_RAMH);
			r = nextRandom();
			memWrite(memAddr(4'h1, {1'b1, r[19:2], 2'b00}), CS_RAML);
			r = nextRandom();
			memWrite(memAddr(4'h2, {1'b1, r[19:2], 2'b00}), CS_SRAM);
			r = nextRandom();
			memWrite(memAddr({1'b1, r[22:20]}, {1'b1, r[19:2], 2'b00}), CS_RAMH);
		end
	endtask

	task automatic nullAndRegisters();
		logic [31:0] d;
		nullAccess(1'b1, memAddr(4'h0, 21'h000100));
		nullAccess(1'b0, memAddr(4'h5, 21'h000200));
		regAccess(1'b1, REG_HOOK, {7'd0, HOOK_TARGET}, d);
		regAccess(1'b0, REG_HOOK, '0, d);
		checkWord("REG_HOOK", d, {7'd0, HOOK_TARGET});
		idle(3);
		// Three idle cycles, no pause, hook flag cleared by the hook write
		regAccess(1'b0, REG_STATUS, '0, d);
		checkWord("REG_STATUS", d, 32'h00000003);
	endtask

	task automatic hookAndBreak();
		logic [31:0] d;
		regAccess(1'b1, REG_CTRL, 32'h00000002, d);
		regAccess(1'b0, REG_CTRL, '0, d);
		checkWord("REG_CTRL", d, 32'h00000002);
		memRead(busAddr_t'(HOOK_TARGET), CS_RAMH);
		idle(1);
		checkBit("dbgHook", dbgHook, 1'b1);
		heldRead(memAddr(4'h1, 21'h100A0C), CS_RAML, 1'b1);
		regAccess(1'b1, REG_CTRL, 32'h00000000, d);
		dbgPause = 1'b1;
		// Pause and hook flag both set with the count just cleared
		regAccess(1'b0, REG_STATUS, '0, d);
		checkWord("REG_STATUS", d, 32'h00000300);
		heldRead(memAddr(4'h2, 21'h100F00), CS_SRAM, 1'b0);
	endtask

	task automatic idleCounter();
		memRead(memAddr(4'h1, 21'h100040), CS_RAML);
		checkWord("dbgWaitCnt", {24'd0, dbgWaitCnt}, 32'd0);
		for (int i = 1; i <= 10; i++) begin
			idle(1);
			checkWord("dbgWaitCnt", {24'd0, dbgWaitCnt}, i);
		end
	endtask

	initial begin
		errCount = 0;
		reported = 1'b0;
		lcgState = 32'h1f8f8a04;
		modelRnd = '0;
		waitLeft = 0;
		inAccess = 1'b0;
		RST_N    = 1'b0;
		wbReq    = '0;
		memDi    = '0;
		memWaitN = 1'b1;
		dbgPause = 1'b0;
		dbgRun   = 1'b0;
		repeat (10) @(posedge CLK);
		#5;
		resetValues();
		RST_N = 1'b1;
		idle(2);
		memoryAccesses();
		nullAndRegisters();
		hookAndBreak();
		idleCounter();
		reported = 1'b1;
		if (errCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Run stopped early, for example by an assertion
	final begin
		if (!reported) begin
			$display("Something failed");
		end
	end

endmodule

// File: sources.f
hw/saturnBusPkg.sv
hw/busRouter.sv
hw/memSequencer.sv
hw/debugRegs.sv
hw/debugMonitor.sv
hw/saturnBus.sv
sim/saturnBus_chk.sv
sim/tbSaturnBus.sv

// File: run.sh
#!/bin/sh
# Build and run the saturnBus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
	--top-module tbSaturnBus -o VtbSaturnBus
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VtbSaturnBus > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0
